//--- axil_pkg.sv
`default_nettype none

package axil_pkg;

    // Bus geometry
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    // 4 KiB of storage
    localparam int mem_words = 1024;
    localparam int word_lsb  = 2;

    // Accepted but unanswered transactions allowed past the pause gate
    localparam int max_outstanding = 3;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axil_resp_e;

    typedef enum logic [1:0] {
        st_run,
        st_drain,
        st_paused
    } pause_state_e;

    // What the RAM core does in a given cycle
    typedef enum logic [1:0] {
        op_idle,
        op_write,
        op_read
    } ram_op_e;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [2:0]            prot;
    } axil_aw_t;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [2:0]            prot;
    } axil_ar_t;

    typedef struct packed {
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        axil_resp_e resp;
    } axil_b_t;

    typedef struct packed {
        logic [data_width-1:0] data;
        axil_resp_e            resp;
    } axil_r_t;

endpackage

`default_nettype wire

//--- axil_pause_gate.sv
`timescale 1ns/1ps
`default_nettype none

module axil_pause_gate import axil_pkg::*; (
    input  wire logic     seq,
    input  wire logic     rst_n,
    input  wire logic     pause_req,
    output logic          pause_ack,
    input  wire axil_aw_t s_aw,
    input  wire logic     s_aw_valid,
    output logic          s_aw_ready,
    input  wire axil_w_t  s_w,
    input  wire logic     s_w_valid,
    output logic          s_w_ready,
    input  wire axil_ar_t s_ar,
    input  wire logic     s_ar_valid,
    output logic          s_ar_ready,
    output axil_b_t       s_b,
    output logic          s_b_valid,
    input  wire logic     s_b_ready,
    output axil_r_t       s_r,
    output logic          s_r_valid,
    input  wire logic     s_r_ready,
    output axil_aw_t      m_aw,
    output logic          m_aw_valid,
    input  wire logic     m_aw_ready,
    output axil_w_t       m_w,
    output logic          m_w_valid,
    input  wire logic     m_w_ready,
    output axil_ar_t      m_ar,
    output logic          m_ar_valid,
    input  wire logic     m_ar_ready,
    input  wire axil_b_t  m_b,
    input  wire logic     m_b_valid,
    output logic          m_b_ready,
    input  wire axil_r_t  m_r,
    input  wire logic     m_r_valid,
    output logic          m_r_ready
);

    pause_state_e      state;
    pause_state_e      state_n;
    logic [2:0]        outstanding;
    // Write addresses accepted minus write data accepted
    logic signed [3:0] w_bal;
    logic              aw_allow;
    logic              w_allow;
    logic              ar_allow;
    logic              aw_fire;
    logic              w_fire;
    logic              ar_fire;
    logic              b_fire;
    logic              r_fire;

    // Writes take the last free slot before reads
    assign aw_allow = !pause_req && (outstanding < max_outstanding);
    assign ar_allow = !pause_req && ((outstanding + 3'(aw_fire)) < max_outstanding);
    // Data still owed to an accepted address is never held back
    assign w_allow  = aw_allow || (w_bal > 4'sd0);

    assign m_aw       = s_aw;
    assign m_aw_valid = s_aw_valid && aw_allow;
    assign s_aw_ready = m_aw_ready && aw_allow;
    assign m_w        = s_w;
    assign m_w_valid  = s_w_valid && w_allow;
    assign s_w_ready  = m_w_ready && w_allow;
    assign m_ar       = s_ar;
    assign m_ar_valid = s_ar_valid && ar_allow;
    assign s_ar_ready = m_ar_ready && ar_allow;

    // Responses are never blocked
    assign s_b       = m_b;
    assign s_b_valid = m_b_valid;
    assign m_b_ready = s_b_ready;
    assign s_r       = m_r;
    assign s_r_valid = m_r_valid;
    assign m_r_ready = s_r_ready;

    assign aw_fire = s_aw_valid && s_aw_ready;
    assign w_fire  = s_w_valid && s_w_ready;
    assign ar_fire = s_ar_valid && s_ar_ready;
    assign b_fire  = s_b_valid && s_b_ready;
    assign r_fire  = s_r_valid && s_r_ready;

    always_comb begin
        state_n = state;
        case (state)
            st_run: begin
                if (pause_req) begin
                    state_n = (outstanding == '0) ? st_paused : st_drain;
                end
            end
            st_drain: begin
                if (!pause_req) begin
                    state_n = st_run;
                end else if (outstanding == '0) begin
                    state_n = st_paused;
                end
            end
            st_paused: begin
                if (!pause_req) begin
                    state_n = st_run;
                end
            end
            default: state_n = st_run;
        endcase
    end

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_run;
            outstanding <= '0;
            w_bal       <= '0;
        end else begin
            state       <= state_n;
            outstanding <= outstanding + 3'(aw_fire) + 3'(ar_fire)
                           - 3'(b_fire) - 3'(r_fire);
            w_bal       <= w_bal + 4'(aw_fire) - 4'(w_fire);
        end
    end

    assign pause_ack = (state == st_paused);

endmodule

`default_nettype wire

//--- axil_skid.sv
`timescale 1ns/1ps
`default_nettype none

module axil_skid import axil_pkg::*; (
    input  wire logic     seq,
    input  wire logic     rst_n,
    input  wire axil_aw_t s_aw,
    input  wire logic     s_aw_valid,
    output logic          s_aw_ready,
    input  wire axil_w_t  s_w,
    input  wire logic     s_w_valid,
    output logic          s_w_ready,
    input  wire axil_ar_t s_ar,
    input  wire logic     s_ar_valid,
    output logic          s_ar_ready,
    output axil_b_t       s_b,
    output logic          s_b_valid,
    input  wire logic     s_b_ready,
    output axil_r_t       s_r,
    output logic          s_r_valid,
    input  wire logic     s_r_ready,
    output axil_aw_t      m_aw,
    output logic          m_aw_valid,
    input  wire logic     m_aw_ready,
    output axil_w_t       m_w,
    output logic          m_w_valid,
    input  wire logic     m_w_ready,
    output axil_ar_t      m_ar,
    output logic          m_ar_valid,
    input  wire logic     m_ar_ready,
    input  wire axil_b_t  m_b,
    input  wire logic     m_b_valid,
    output logic          m_b_ready,
    input  wire axil_r_t  m_r,
    input  wire logic     m_r_valid,
    output logic          m_r_ready
);

    // Wide enough for the largest request payload
    typedef logic [$bits(axil_w_t)-1:0] slot_t;

    // Index 0 is AW, 1 is W, 2 is AR
    slot_t [2:0] in_data;
    slot_t [2:0] out_data;
    logic  [2:0] in_valid;
    logic  [2:0] in_ready;
    logic  [2:0] out_valid;
    logic  [2:0] out_ready;

    assign in_data  = {slot_t'(s_ar), slot_t'(s_w), slot_t'(s_aw)};
    assign in_valid = {s_ar_valid, s_w_valid, s_aw_valid};
    assign out_ready = {m_ar_ready, m_w_ready, m_aw_ready};

    assign s_aw_ready = in_ready[0];
    assign s_w_ready  = in_ready[1];
    assign s_ar_ready = in_ready[2];
    assign m_aw_valid = out_valid[0];
    assign m_w_valid  = out_valid[1];
    assign m_ar_valid = out_valid[2];
    assign m_aw = axil_aw_t'(out_data[0][$bits(axil_aw_t)-1:0]);
    assign m_w  = axil_w_t'(out_data[1]);
    assign m_ar = axil_ar_t'(out_data[2][$bits(axil_ar_t)-1:0]);

    for (genvar g = 0; g < 3; g++) begin : g_chan
        slot_t main_q;
        slot_t skid_q;
        logic  main_vld;
        logic  skid_vld;
        logic  rdy_q;
        logic  main_vld_n;
        logic  skid_vld_n;
        logic  load_main;
        logic  load_skid;
        logic  in_fire;
        logic  out_fire;

        assign in_fire  = in_valid[g] && rdy_q;
        assign out_fire = main_vld && out_ready[g];

        always_comb begin
            main_vld_n = main_vld;
            skid_vld_n = skid_vld;
            load_main  = 1'b0;
            load_skid  = 1'b0;
            if (!main_vld || out_fire) begin
                // Output stage refills from the skid entry first
                main_vld_n = skid_vld || in_fire;
                skid_vld_n = 1'b0;
                load_main  = skid_vld || in_fire;
            end else if (in_fire) begin
                skid_vld_n = 1'b1;
                load_skid  = 1'b1;
            end
        end

        always_ff @(posedge seq or negedge rst_n) begin
            if (!rst_n) begin
                main_vld <= 1'b0;
                skid_vld <= 1'b0;
                rdy_q    <= 1'b0;
            end else begin
                main_vld <= main_vld_n;
                skid_vld <= skid_vld_n;
                rdy_q    <= !skid_vld_n;
            end
        end

        always_ff @(posedge seq) begin
            if (load_main) begin
                main_q <= skid_vld ? skid_q : in_data[g];
            end
            if (load_skid) begin
                skid_q <= in_data[g];
            end
        end

        assign in_ready[g]  = rdy_q;
        assign out_valid[g] = main_vld;
        assign out_data[g]  = main_q;
    end

    // Responses are already registered by the core
    assign s_b       = m_b;
    assign s_b_valid = m_b_valid;
    assign m_b_ready = s_b_ready;
    assign s_r       = m_r;
    assign s_r_valid = m_r_valid;
    assign m_r_ready = s_r_ready;

endmodule

`default_nettype wire

//--- axil_ram_core.sv
`timescale 1ns/1ps
`default_nettype none

module axil_ram_core import axil_pkg::*; (
    input  wire logic     seq,
    input  wire logic     rst_n,
    input  wire logic     pause_req,
    output logic          pause_ack,
    input  wire axil_aw_t s_aw,
    input  wire logic     s_aw_valid,
    output logic          s_aw_ready,
    input  wire axil_w_t  s_w,
    input  wire logic     s_w_valid,
    output logic          s_w_ready,
    input  wire axil_ar_t s_ar,
    input  wire logic     s_ar_valid,
    output logic          s_ar_ready,
    output axil_b_t       s_b,
    output logic          s_b_valid,
    input  wire logic     s_b_ready,
    output axil_r_t       s_r,
    output logic          s_r_valid,
    input  wire logic     s_r_ready
);

    // Gate to skid buffer
    axil_aw_t p_aw;
    axil_w_t  p_w;
    axil_ar_t p_ar;
    axil_b_t  p_b;
    axil_r_t  p_r;
    logic     p_aw_valid, p_aw_ready, p_w_valid, p_w_ready, p_ar_valid, p_ar_ready;
    logic     p_b_valid, p_b_ready, p_r_valid, p_r_ready;

    // Skid buffer to RAM logic
    axil_aw_t k_aw;
    axil_w_t  k_w;
    axil_ar_t k_ar;
    axil_b_t  k_b;
    axil_r_t  k_r;
    logic     k_aw_valid, k_aw_ready, k_w_valid, k_w_ready, k_ar_valid, k_ar_ready;
    logic     k_b_valid, k_b_ready, k_r_valid, k_r_ready;

    axil_pause_gate u_gate (
        .seq, .rst_n, .pause_req, .pause_ack,
        .s_aw, .s_aw_valid, .s_aw_ready, .s_w, .s_w_valid, .s_w_ready,
        .s_ar, .s_ar_valid, .s_ar_ready, .s_b, .s_b_valid, .s_b_ready,
        .s_r, .s_r_valid, .s_r_ready,
        .m_aw (p_aw), .m_aw_valid (p_aw_valid), .m_aw_ready (p_aw_ready),
        .m_w  (p_w),  .m_w_valid  (p_w_valid),  .m_w_ready  (p_w_ready),
        .m_ar (p_ar), .m_ar_valid (p_ar_valid), .m_ar_ready (p_ar_ready),
        .m_b  (p_b),  .m_b_valid  (p_b_valid),  .m_b_ready  (p_b_ready),
        .m_r  (p_r),  .m_r_valid  (p_r_valid),  .m_r_ready  (p_r_ready)
    );

    axil_skid u_skid (
        .seq, .rst_n,
        .s_aw (p_aw), .s_aw_valid (p_aw_valid), .s_aw_ready (p_aw_ready),
        .s_w  (p_w),  .s_w_valid  (p_w_valid),  .s_w_ready  (p_w_ready),
        .s_ar (p_ar), .s_ar_valid (p_ar_valid), .s_ar_ready (p_ar_ready),
        .s_b  (p_b),  .s_b_valid  (p_b_valid),  .s_b_ready  (p_b_ready),
        .s_r  (p_r),  .s_r_valid  (p_r_valid),  .s_r_ready  (p_r_ready),
        .m_aw (k_aw), .m_aw_valid (k_aw_valid), .m_aw_ready (k_aw_ready),
        .m_w  (k_w),  .m_w_valid  (k_w_valid),  .m_w_ready  (k_w_ready),
        .m_ar (k_ar), .m_ar_valid (k_ar_valid), .m_ar_ready (k_ar_ready),
        .m_b  (k_b),  .m_b_valid  (k_b_valid),  .m_b_ready  (k_b_ready),
        .m_r  (k_r),  .m_r_valid  (k_r_valid),  .m_r_ready  (k_r_ready)
    );

    logic [strb_width-1:0][7:0]     mem [mem_words];
    logic [addr_width-word_lsb-1:0] wr_word;
    logic [addr_width-word_lsb-1:0] rd_word;
    logic                           wr_hit;
    logic                           rd_hit;
    ram_op_e                        op;
    logic                           b_valid_q;
    logic                           r_valid_q;
    axil_resp_e                     b_resp_q;
    axil_resp_e                     r_resp_q;
    logic [data_width-1:0]          rdata_q;

    // Byte offset bits are dropped
    assign wr_word = k_aw.addr[addr_width-1:word_lsb];
    assign rd_word = k_ar.addr[addr_width-1:word_lsb];
    assign wr_hit  = wr_word < mem_words;
    assign rd_hit  = rd_word < mem_words;

    // Writes win, each needs its response slot free
    always_comb begin
        op = op_idle;
        if (k_aw_valid && k_w_valid && (!b_valid_q || k_b_ready)) begin
            op = op_write;
        end else if (k_ar_valid && (!r_valid_q || k_r_ready)) begin
            op = op_read;
        end
    end

    assign k_aw_ready = (op == op_write);
    assign k_w_ready  = (op == op_write);
    assign k_ar_ready = (op == op_read);

    always_ff @(posedge seq) begin
        if (op == op_write) begin
            if (wr_hit) begin
                for (int i = 0; i < strb_width; i++) begin
                    if (k_w.strb[i]) begin
                        mem[wr_word[$clog2(mem_words)-1:0]][i] <= k_w.data[8*i +: 8];
                    end
                end
            end
            b_resp_q <= wr_hit ? resp_okay : resp_decerr;
        end
        if (op == op_read) begin
            rdata_q  <= rd_hit ? mem[rd_word[$clog2(mem_words)-1:0]] : '0;
            r_resp_q <= rd_hit ? resp_okay : resp_decerr;
        end
    end

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            if (op == op_write) begin
                b_valid_q <= 1'b1;
            end else if (k_b_ready) begin
                b_valid_q <= 1'b0;
            end
            if (op == op_read) begin
                r_valid_q <= 1'b1;
            end else if (k_r_ready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    assign k_b       = '{resp: b_resp_q};
    assign k_b_valid = b_valid_q;
    assign k_r       = '{data: rdata_q, resp: r_resp_q};
    assign k_r_valid = r_valid_q;

endmodule

`default_nettype wire

//--- axil_ram_top.sv
`timescale 1ns/1ps
`default_nettype none

module axil_ram_top import axil_pkg::*; (
    input  wire logic     seq,
    input  wire logic     rst_n,
    input  wire logic     pause_req,
    output logic          pause_ack,
    input  wire axil_aw_t s_aw,
    input  wire logic     s_aw_valid,
    output logic          s_aw_ready,
    input  wire axil_w_t  s_w,
    input  wire logic     s_w_valid,
    output logic          s_w_ready,
    input  wire axil_ar_t s_ar,
    input  wire logic     s_ar_valid,
    output logic          s_ar_ready,
    output axil_b_t       s_b,
    output logic          s_b_valid,
    input  wire logic     s_b_ready,
    output axil_r_t       s_r,
    output logic          s_r_valid,
    input  wire logic     s_r_ready
);

    // External bus straight into the RAM target
    axil_ram_core u_core (
        .seq        (seq),
        .rst_n      (rst_n),
        .pause_req  (pause_req),
        .pause_ack  (pause_ack),
        .s_aw       (s_aw),
        .s_aw_valid (s_aw_valid),
        .s_aw_ready (s_aw_ready),
        .s_w        (s_w),
        .s_w_valid  (s_w_valid),
        .s_w_ready  (s_w_ready),
        .s_ar       (s_ar),
        .s_ar_valid (s_ar_valid),
        .s_ar_ready (s_ar_ready),
        .s_b        (s_b),
        .s_b_valid  (s_b_valid),
        .s_b_ready  (s_b_ready),
        .s_r        (s_r),
        .s_r_valid  (s_r_valid),
        .s_r_ready  (s_r_ready)
    );

endmodule

`default_nettype wire

//--- axil_ram_sva.sv
`timescale 1ns/1ps
`default_nettype none

module axil_ram_sva import axil_pkg::*; (
    input wire logic     seq,
    input wire logic     rst_n,
    input wire logic     pause_ack,
    input wire axil_aw_t s_aw,
    input wire logic     s_aw_valid,
    input wire logic     s_aw_ready,
    input wire axil_w_t  s_w,
    input wire logic     s_w_valid,
    input wire logic     s_w_ready,
    input wire axil_ar_t s_ar,
    input wire logic     s_ar_valid,
    input wire logic     s_ar_ready,
    input wire axil_b_t  s_b,
    input wire logic     s_b_valid,
    input wire logic     s_b_ready,
    input wire axil_r_t  s_r,
    input wire logic     s_r_valid,
    input wire logic     s_r_ready
);

    logic       reset_seen = 1'b0;
    // Accepted requests still waiting for their response
    logic [3:0] wr_open;
    logic [3:0] rd_open;

    always @(posedge seq) begin
        if (!rst_n) begin
            reset_seen <= 1'b1;
        end
    end

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            wr_open <= '0;
            rd_open <= '0;
        end else begin
            wr_open <= wr_open + 4'(s_aw_valid && s_aw_ready) - 4'(s_b_valid && s_b_ready);
            rd_open <= rd_open + 4'(s_ar_valid && s_ar_ready) - 4'(s_r_valid && s_r_ready);
        end
    end

    aw_hold: assert property (@(posedge seq) disable iff (!rst_n)
        s_aw_valid && !s_aw_ready |=> s_aw_valid && $stable(s_aw))
        else $error("AW valid or payload changed before ready");
    w_hold: assert property (@(posedge seq) disable iff (!rst_n)
        s_w_valid && !s_w_ready |=> s_w_valid && $stable(s_w))
        else $error("W valid or payload changed before ready");
    ar_hold: assert property (@(posedge seq) disable iff (!rst_n)
        s_ar_valid && !s_ar_ready |=> s_ar_valid && $stable(s_ar))
        else $error("AR valid or payload changed before ready");
    b_hold: assert property (@(posedge seq) disable iff (!rst_n)
        s_b_valid && !s_b_ready |=> s_b_valid && $stable(s_b))
        else $error("B valid or payload changed before ready");
    r_hold: assert property (@(posedge seq) disable iff (!rst_n)
        s_r_valid && !s_r_ready |=> s_r_valid && $stable(s_r))
        else $error("R valid or payload changed before ready");

    reset_quiet: assert property (@(posedge seq) reset_seen && !rst_n |->
        !s_b_valid && !s_r_valid && !pause_ack && !s_aw_ready && !s_w_ready && !s_ar_ready)
        else $error("Outputs active during reset");

    b_has_cause: assert property (@(posedge seq) disable iff (!rst_n)
        s_b_valid |-> wr_open != '0)
        else $error("B valid without an accepted write");
    r_has_cause: assert property (@(posedge seq) disable iff (!rst_n)
        s_r_valid |-> rd_open != '0)
        else $error("R valid without an accepted read");

endmodule

`default_nettype wire

//--- tb_axil_ram.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axil_ram import axil_pkg::*; ();

    localparam int          clk_half       = 4;
    localparam int          sample_delay   = 2;
    localparam int          reset_cycles   = 10;
    localparam int          timeout_cycles = 20000;
    localparam int          rand_writes    = 24;
    localparam int          stall_cycles   = 30;
    localparam int          pause_hold     = 12;
    localparam logic [31:0] rand_seed      = 32'h4852;

    logic     seq;
    logic     rst_n;
    logic     pause_req;
    logic     pause_ack;
    axil_aw_t s_aw;
    axil_w_t  s_w;
    axil_ar_t s_ar;
    axil_b_t  s_b;
    axil_r_t  s_r;
    logic     s_aw_valid, s_aw_ready, s_w_valid, s_w_ready, s_ar_valid, s_ar_ready;
    logic     s_b_valid, s_b_ready, s_r_valid, s_r_ready;

    // Expected memory contents
    logic [data_width-1:0] model [mem_words];
    // Words fully written at least once
    bit                    known [mem_words];
    int                    errors  = 0;
    int                    checks  = 0;
    int                    cycles  = 0;
    int                    pending = 0;
    bit                    rd_accepted;

    axil_ram_top DUT (
        .seq, .rst_n, .pause_req, .pause_ack,
        .s_aw, .s_aw_valid, .s_aw_ready, .s_w, .s_w_valid, .s_w_ready,
        .s_ar, .s_ar_valid, .s_ar_ready, .s_b, .s_b_valid, .s_b_ready,
        .s_r, .s_r_valid, .s_r_ready
    );

    bind axil_ram_top axil_ram_sva u_sva (
        .seq, .rst_n, .pause_ack,
        .s_aw, .s_aw_valid, .s_aw_ready, .s_w, .s_w_valid, .s_w_ready,
        .s_ar, .s_ar_valid, .s_ar_ready, .s_b, .s_b_valid, .s_b_ready,
        .s_r, .s_r_valid, .s_r_ready
    );

    initial begin
        seq = 1'b0;
        forever #clk_half seq = ~seq;
    end

    always @(posedge seq) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: tests still running after %0d clock cycles", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic check_cond(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("FAILED at %0d ns: %s", $time, what);
        end
    endtask

    // Only in-range words change, and only in enabled byte lanes
    function automatic void apply_write(input logic [31:0] addr, input logic [31:0] data,
                                        input logic [3:0] strb);
        int idx;
        idx = int'(addr >> word_lsb);
        if (idx < mem_words) begin
            for (int i = 0; i < strb_width; i++) begin
                if (strb[i]) begin
                    model[idx][8*i +: 8] = data[8*i +: 8];
                end
            end
            if (strb == '1) begin
                known[idx] = 1'b1;
            end
        end
    endfunction

    task automatic send_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        bit aw_hit;
        bit w_hit;
        apply_write(addr, data, strb);
        @(negedge seq);
        s_aw       = '{addr: addr, prot: 3'b000};
        s_aw_valid = 1'b1;
        s_w        = '{data: data, strb: strb};
        s_w_valid  = 1'b1;
        while (s_aw_valid || s_w_valid) begin
            #sample_delay;
            aw_hit = s_aw_valid && s_aw_ready;
            w_hit  = s_w_valid && s_w_ready;
            @(negedge seq);
            if (aw_hit) begin
                s_aw_valid = 1'b0;
                pending++;
                check_cond(pending <= max_outstanding,
                           $sformatf("%0d transactions pending", pending));
            end
            if (w_hit) begin
                s_w_valid = 1'b0;
            end
        end
    endtask

    task automatic send_read(input logic [31:0] addr);
        bit hit;
        hit = 1'b0;
        @(negedge seq);
        s_ar       = '{addr: addr, prot: 3'b000};
        s_ar_valid = 1'b1;
        while (!hit) begin
            #sample_delay;
            hit = s_ar_ready;
            @(negedge seq);
        end
        s_ar_valid = 1'b0;
        pending++;
        check_cond(pending <= max_outstanding, $sformatf("%0d transactions pending", pending));
    endtask

    task automatic take_b(input axil_resp_e exp_resp);
        bit      got;
        axil_b_t b;
        got = 1'b0;
        @(negedge seq);
        s_b_ready = 1'b1;
        while (!got) begin
            #sample_delay;
            got = s_b_valid;
            b   = s_b;
            @(negedge seq);
        end
        s_b_ready = 1'b0;
        pending--;
        check_cond(b.resp == exp_resp,
                   $sformatf("write response %0d, expected %0d", b.resp, exp_resp));
    endtask

    task automatic take_r(input logic [31:0] exp_data, input axil_resp_e exp_resp);
        bit      got;
        axil_r_t r;
        got = 1'b0;
        @(negedge seq);
        s_r_ready = 1'b1;
        while (!got) begin
            #sample_delay;
            got = s_r_valid;
            r   = s_r;
            @(negedge seq);
        end
        s_r_ready = 1'b0;
        pending--;
        check_cond(r.resp == exp_resp,
                   $sformatf("read response %0d, expected %0d", r.resp, exp_resp));
        check_cond(r.data === exp_data,
                   $sformatf("read data %h, expected %h", r.data, exp_data));
    endtask

    task automatic basic_write_read();
        logic [31:0] data;
        data = $urandom;
        send_write(32'h0000_0010, data, 4'hf);
        take_b(resp_okay);
        send_read(32'h0000_0010);
        take_r(data, resp_okay);
    endtask

    task automatic partial_strobe_writes();
        int          idx;
        logic [31:0] addr;
        repeat (rand_writes) begin
            idx  = $urandom_range(mem_words - 1, 0);
            addr = (idx << word_lsb) | $urandom_range(3, 0);
            if (!known[idx]) begin
                send_write(addr, $urandom, 4'hf);
                take_b(resp_okay);
            end
            send_write(addr, $urandom, 4'($urandom_range(14, 1)));
            take_b(resp_okay);
            send_read(idx << word_lsb);
            take_r(model[idx], resp_okay);
        end
    endtask

    task automatic out_of_range_access();
        logic [31:0] base;
        base = $urandom;
        send_write(32'h0, base, 4'hf);
        take_b(resp_okay);
        // First word past the end would alias word 0 if decoded short
        send_write(mem_words << word_lsb, ~base, 4'hf);
        take_b(resp_decerr);
        send_read(mem_words << word_lsb);
        take_r('0, resp_decerr);
        send_write(32'hffff_fffc, ~base, 4'h3);
        take_b(resp_decerr);
        send_read(32'hffff_fffc);
        take_r('0, resp_decerr);
        send_read(32'h0);
        take_r(model[0], resp_okay);
    endtask

    task automatic stalled_responses();
        logic [31:0] datas [4];
        foreach (datas[i]) begin
            datas[i] = $urandom;
        end
        fork
            begin
                for (int i = 0; i < 4; i++) begin
                    send_write(32'h100 + 4 * i, datas[i], 4'hf);
                end
                for (int i = 0; i < 2; i++) begin
                    send_read(32'h100 + 4 * i);
                end
            end
            begin
                repeat (stall_cycles) @(negedge seq);
                #sample_delay;
                check_cond(pending == max_outstanding,
                           $sformatf("%0d requests accepted while stalled", pending));
                check_cond(!s_aw_ready && !s_w_ready && !s_ar_ready,
                           "request readies still high under back-pressure");
                for (int i = 0; i < 4; i++) begin
                    take_b(resp_okay);
                end
                for (int i = 0; i < 2; i++) begin
                    take_r(datas[i], resp_okay);
                end
            end
        join
    endtask

    task automatic pause_and_drain();
        logic [31:0] data;
        data = $urandom;
        send_write(32'h200, data, 4'hf);
        send_write(32'h204, ~data, 4'hf);
        @(negedge seq);
        pause_req   = 1'b1;
        rd_accepted = 1'b0;
        fork
            begin
                send_read(32'h200);
                rd_accepted = 1'b1;
            end
        join_none
        repeat (pause_hold) @(negedge seq);
        #sample_delay;
        check_cond(!pause_ack, "pause_ack high with responses outstanding");
        check_cond(!s_ar_ready && !rd_accepted, "read accepted while paused");
        take_b(resp_okay);
        take_b(resp_okay);
        #sample_delay;
        check_cond(!pause_ack, "pause_ack high in the cycle the count reached zero");
        @(negedge seq);
        #sample_delay;
        check_cond(pause_ack, "pause_ack low after drain");
        check_cond(!rd_accepted, "read accepted while paused");
        @(negedge seq);
        pause_req = 1'b0;
        @(negedge seq);
        #sample_delay;
        check_cond(!pause_ack, "pause_ack still high after pause_req fell");
        wait (rd_accepted);
        take_r(data, resp_okay);
    endtask

    // Write and read of one word presented together
    task automatic same_cycle_write_read();
        logic [31:0] data;
        data = $urandom;
        send_write(32'h300, data, 4'hf);
        take_b(resp_okay);
        fork
            send_write(32'h300, ~data, 4'hf);
            send_read(32'h300);
        join
        take_b(resp_okay);
        take_r(~data, resp_okay);
    endtask

    initial begin
        rst_n      = 1'b0;
        pause_req  = 1'b0;
        s_aw       = '0;
        s_aw_valid = 1'b0;
        s_w        = '0;
        s_w_valid  = 1'b0;
        s_ar       = '0;
        s_ar_valid = 1'b0;
        s_b_ready  = 1'b0;
        s_r_ready  = 1'b0;
        void'($urandom(rand_seed));
        repeat (reset_cycles) @(posedge seq);
        @(negedge seq);
        rst_n = 1'b1;
        basic_write_read();
        partial_strobe_writes();
        out_of_range_access();
        stalled_responses();
        pause_and_drain();
        same_cycle_write_read();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
axil_pkg.sv
axil_pause_gate.sv
axil_skid.sv
axil_ram_core.sv
axil_ram_top.sv
axil_ram_sva.sv
tb_axil_ram.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_axil_ram
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -qF '*** PASSED ***' $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
